/* logic/axi_bus_pkg.sv */
// single-beat AXI4 subset with a 64-bit data lane, no IDs, no bursts and no lock field
package axi_bus_pkg;

  // ------------------------------------------------------------------
  // widths that carry a meaning
  // ------------------------------------------------------------------
  typedef logic [31:0] addr_t;  // byte address
  typedef logic [63:0] data_t;  // one beat
  typedef logic [7:0]  strb_t;  // byte enables
  typedef logic [1:0]  size_t;  // 0..3 -> 1, 2, 4, 8 bytes
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  len_t;   // beats minus one

  // ------------------------------------------------------------------
  // fixed AXI encodings
  // ------------------------------------------------------------------
  localparam resp_t      RESP_OKAY               = 2'b00;
  localparam resp_t      RESP_SLVERR             = 2'b10;
  localparam len_t       LEN_SINGLE              = 8'd0;
  localparam logic [1:0] BURST_INCR              = 2'b01;
  localparam logic [3:0] CACHE_DEV_NONBUF        = 4'b0000;
  localparam logic [2:0] PROT_DATA_SECURE_UNPRIV = 3'b000;
  localparam size_t      SIZE_DWORD              = 2'd3;  // full 8-byte beat

  // ------------------------------------------------------------------
  // CPU side
  // ------------------------------------------------------------------
  typedef struct packed {
    logic  wr;    // 1 = write
    size_t size;
    addr_t addr;
    strb_t strb;
    data_t data;
  } rw_req_t;

  typedef struct packed {
    logic  err;   // resp was not OKAY
    data_t rdata;
  } rw_rsp_t;

  // ------------------------------------------------------------------
  // AXI channel payloads, AW and AR share one layout
  // ------------------------------------------------------------------
  typedef struct packed {
    addr_t      addr;
    len_t       len;
    size_t      size;
    logic [1:0] burst;
    logic [3:0] cache;
    logic [2:0] prot;
  } axi_a_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
  } axi_r_t;

endpackage

/* logic/rw_arbiter.sv */
// two requesters, one transaction in flight; requests must stay up until addr_ok
`timescale 1ns/1ps

module rw_arbiter (
  input  logic                   i_aclk,
  input  logic                   i_rst,

  // instruction fetch, read only
  input  logic                   i_if_req,
  input  axi_bus_pkg::addr_t     i_if_addr,
  output logic                   o_if_addr_ok,
  output logic                   o_if_data_ok,
  output axi_bus_pkg::rw_rsp_t   o_if_rsp,

  // data port
  input  logic                   i_mem_req,
  input  axi_bus_pkg::rw_req_t   i_mem_cmd,
  output logic                   o_mem_addr_ok,
  output logic                   o_mem_data_ok,
  output axi_bus_pkg::rw_rsp_t   o_mem_rsp,

  // towards the bridge
  output logic                   o_req_valid,
  output axi_bus_pkg::rw_req_t   o_req,
  input  logic                   i_req_accept,
  input  logic                   i_done,
  input  axi_bus_pkg::rw_rsp_t   i_rsp
);

  import axi_bus_pkg::*;

  logic    last_mem_q;  // 1 = data port was served last
  logic    owner_mem_q; // owner of the transaction in flight
  logic    pick_mem;
  rw_req_t fetch_cmd;

  // ------------------------------------------------------------------
  // choice
  // ------------------------------------------------------------------
  // on a tie the port not served last wins
  assign pick_mem = i_mem_req & (~i_if_req | ~last_mem_q);

  assign fetch_cmd = '{
    wr:   1'b0,
    size: SIZE_DWORD,
    addr: i_if_addr,
    strb: '0,
    data: '0
  };

  assign o_req_valid = i_if_req | i_mem_req;
  assign o_req       = pick_mem ? i_mem_cmd : fetch_cmd;

  assign o_if_addr_ok  = i_req_accept & ~pick_mem;
  assign o_mem_addr_ok = i_req_accept & pick_mem;

  // ------------------------------------------------------------------
  // owner and fairness state
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      last_mem_q  <= 1'b1;  // fetch first after reset
      owner_mem_q <= 1'b0;
    end else begin
      if (i_req_accept) begin
        owner_mem_q <= pick_mem;
      end
      if (i_done) begin
        last_mem_q <= owner_mem_q;  // counts as served once it completes
      end
    end
  end

  // ------------------------------------------------------------------
  // response routing
  // ------------------------------------------------------------------
  assign o_if_data_ok  = i_done & ~owner_mem_q;
  assign o_mem_data_ok = i_done & owner_mem_q;

  assign o_if_rsp  = owner_mem_q ? '0 : i_rsp;
  assign o_mem_rsp = owner_mem_q ? i_rsp : '0;

endmodule

/* logic/axi_master_bridge.sv */
// single-beat AXI4 master, one transaction at a time, never back-pressures B or R
`timescale 1ns/1ps

module axi_master_bridge (
  input  logic                   i_aclk,
  input  logic                   i_rst,

  // request side
  input  logic                   i_req_valid,
  input  axi_bus_pkg::rw_req_t   i_req,
  output logic                   o_req_accept,
  output logic                   o_done,
  output axi_bus_pkg::rw_rsp_t   o_rsp,

  // write address
  output axi_bus_pkg::axi_a_t    o_aw,
  output logic                   o_awvalid,
  input  logic                   i_awready,

  // write data
  output axi_bus_pkg::axi_w_t    o_w,
  output logic                   o_wvalid,
  input  logic                   i_wready,

  // write response
  input  axi_bus_pkg::resp_t     i_bresp,
  input  logic                   i_bvalid,
  output logic                   o_bready,

  // read address
  output axi_bus_pkg::axi_a_t    o_ar,
  output logic                   o_arvalid,
  input  logic                   i_arready,

  // read data
  input  axi_bus_pkg::axi_r_t    i_r,
  input  logic                   i_rvalid,
  output logic                   o_rready
);

  import axi_bus_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  rd_state_e rd_state_q;
  wr_state_e wr_state_q;
  rw_req_t   req_q;      // command latched at accept
  rw_rsp_t   rsp_q;
  logic      done_q;
  axi_a_t    a_cmd;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = o_bready  & i_bvalid;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready  & i_rvalid;

  // idle on both sides and the last done already delivered
  assign o_req_accept = i_req_valid & (rd_state_q == RD_IDLE) &
                        (wr_state_q == WR_IDLE) & ~done_q;

  always_ff @(posedge i_aclk) begin
    if (o_req_accept) begin
      req_q <= i_req;
    end
  end

  // ------------------------------------------------------------------
  // state machines
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state_q <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: if (o_req_accept && !i_req.wr) rd_state_q <= RD_ADDR;
        RD_ADDR: if (ar_fire) rd_state_q <= RD_DATA;
        RD_DATA: if (r_fire)  rd_state_q <= RD_IDLE;
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state_q <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: if (o_req_accept && i_req.wr) wr_state_q <= WR_ADDR;
        WR_ADDR: if (aw_fire) wr_state_q <= WR_DATA;
        WR_DATA: if (w_fire)  wr_state_q <= WR_RESP;
        WR_RESP: if (b_fire)  wr_state_q <= WR_IDLE;
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // AXI channel drive
  // ------------------------------------------------------------------
  assign a_cmd = '{
    addr:  req_q.addr,
    len:   LEN_SINGLE,
    size:  req_q.size,
    burst: BURST_INCR,
    cache: CACHE_DEV_NONBUF,
    prot:  PROT_DATA_SECURE_UNPRIV
  };

  assign o_aw      = a_cmd;
  assign o_awvalid = (wr_state_q == WR_ADDR);
  assign o_w       = '{data: req_q.data, strb: req_q.strb, last: 1'b1};
  assign o_wvalid  = (wr_state_q == WR_DATA);
  assign o_bready  = (wr_state_q == WR_RESP);

  assign o_ar      = a_cmd;
  assign o_arvalid = (rd_state_q == RD_ADDR);
  assign o_rready  = (rd_state_q == RD_DATA);

  // ------------------------------------------------------------------
  // response, one registered cycle after R or B
  // ------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= r_fire | b_fire;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      rsp_q <= '{err: (i_r.resp != RESP_OKAY), rdata: i_r.data};
    end else if (b_fire) begin
      rsp_q <= '{err: (i_bresp != RESP_OKAY), rdata: '0};
    end
  end

  assign o_done = done_q;
  assign o_rsp  = rsp_q;

endmodule

/* logic/axi_sram_slave.sv */
// single-beat AXI4 SRAM slave, MEM_WORDS of at least 2; W is taken only after AW
`timescale 1ns/1ps

module axi_sram_slave #(
  parameter int MEM_WORDS = 256
) (
  input  logic                   i_aclk,
  input  logic                   i_rst,

  input  axi_bus_pkg::axi_a_t    i_aw,
  input  logic                   i_awvalid,
  output logic                   o_awready,

  input  axi_bus_pkg::axi_w_t    i_w,
  input  logic                   i_wvalid,
  output logic                   o_wready,

  output axi_bus_pkg::resp_t     o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,

  input  axi_bus_pkg::axi_a_t    i_ar,
  input  logic                   i_arvalid,
  output logic                   o_arready,

  output axi_bus_pkg::axi_r_t    o_r,
  output logic                   o_rvalid,
  input  logic                   i_rready
);

  import axi_bus_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  typedef enum logic [1:0] {
    WS_IDLE,
    WS_WAIT_DATA,
    WS_RESP
  } wr_state_e;

  typedef enum logic {
    RS_IDLE,
    RS_RESP
  } rd_state_e;

  data_t mem [MEM_WORDS];

  wr_state_e        wr_state_q;
  rd_state_e        rd_state_q;
  logic [IDX_W-1:0] aw_idx_q;
  logic             aw_err_q;   // range or alignment fault on AW
  resp_t            bresp_q;
  axi_r_t           r_q;
  logic [IDX_W-1:0] ar_idx;
  logic             ar_err;
  logic             aw_err;

  // address not a multiple of the access size
  function automatic logic misaligned(addr_t a, size_t s);
    case (s)
      2'd0:    return 1'b0;
      2'd1:    return a[0];
      2'd2:    return |a[1:0];
      default: return |a[2:0];
    endcase
  endfunction

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------
  assign aw_err = ({3'b000, i_aw.addr[31:3]} >= addr_t'(MEM_WORDS)) |
                  misaligned(i_aw.addr, i_aw.size);
  assign ar_err = ({3'b000, i_ar.addr[31:3]} >= addr_t'(MEM_WORDS)) |
                  misaligned(i_ar.addr, i_ar.size);
  assign ar_idx = i_ar.addr[3 +: IDX_W];

  // ------------------------------------------------------------------
  // write side
  // ------------------------------------------------------------------
  assign o_awready = (wr_state_q == WS_IDLE);
  assign o_wready  = (wr_state_q == WS_WAIT_DATA);
  assign o_bvalid  = (wr_state_q == WS_RESP);
  assign o_bresp   = bresp_q;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state_q <= WS_IDLE;
    end else begin
      case (wr_state_q)
        WS_IDLE:      if (i_awvalid) wr_state_q <= WS_WAIT_DATA;
        WS_WAIT_DATA: if (i_wvalid)  wr_state_q <= WS_RESP;
        WS_RESP:      if (i_bready)  wr_state_q <= WS_IDLE;
        default:      wr_state_q <= WS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (o_awready && i_awvalid) begin
      aw_idx_q <= i_aw.addr[3 +: IDX_W];
      aw_err_q <= aw_err;
    end
    if (o_wready && i_wvalid) begin
      bresp_q <= aw_err_q ? RESP_SLVERR : RESP_OKAY;
      if (!aw_err_q) begin
        for (int b = 0; b < 8; b++) begin
          if (i_w.strb[b]) mem[aw_idx_q][b*8 +: 8] <= i_w.data[b*8 +: 8];  // byte lane
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // read side
  // ------------------------------------------------------------------
  assign o_arready = (rd_state_q == RS_IDLE);
  assign o_rvalid  = (rd_state_q == RS_RESP);
  assign o_r       = r_q;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state_q <= RS_IDLE;
    end else begin
      case (rd_state_q)
        RS_IDLE: if (i_arvalid) rd_state_q <= RS_RESP;
        RS_RESP: if (i_rready)  rd_state_q <= RS_IDLE;
        default: rd_state_q <= RS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (o_arready && i_arvalid) begin
      r_q.data <= ar_err ? '0 : mem[ar_idx];  // zero data on fault
      r_q.resp <= ar_err ? RESP_SLVERR : RESP_OKAY;
      r_q.last <= 1'b1;
    end
  end

endmodule

/* logic/mem_subsys_top.sv */
// closed memory subsystem, reachable only through the fetch and data requester ports
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic                   i_aclk,
  input  logic                   i_rst,

  input  logic                   i_if_req,
  input  axi_bus_pkg::addr_t     i_if_addr,
  output logic                   o_if_addr_ok,
  output logic                   o_if_data_ok,
  output axi_bus_pkg::rw_rsp_t   o_if_rsp,

  input  logic                   i_mem_req,
  input  axi_bus_pkg::rw_req_t   i_mem_cmd,
  output logic                   o_mem_addr_ok,
  output logic                   o_mem_data_ok,
  output axi_bus_pkg::rw_rsp_t   o_mem_rsp
);

  import axi_bus_pkg::*;

  // ------------------------------------------------------------------
  // arbiter to bridge
  // ------------------------------------------------------------------
  logic    req_valid;
  rw_req_t req;
  logic    req_accept;
  logic    done;
  rw_rsp_t rsp;

  // ------------------------------------------------------------------
  // bridge to slave
  // ------------------------------------------------------------------
  axi_a_t aw;
  logic   awvalid;
  logic   awready;
  axi_w_t w;
  logic   wvalid;
  logic   wready;
  resp_t  bresp;
  logic   bvalid;
  logic   bready;
  axi_a_t ar;
  logic   arvalid;
  logic   arready;
  axi_r_t r;
  logic   rvalid;
  logic   rready;

  rw_arbiter rw_arbiter_i (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_if_req      (i_if_req),
    .i_if_addr     (i_if_addr),
    .o_if_addr_ok  (o_if_addr_ok),
    .o_if_data_ok  (o_if_data_ok),
    .o_if_rsp      (o_if_rsp),
    .i_mem_req     (i_mem_req),
    .i_mem_cmd     (i_mem_cmd),
    .o_mem_addr_ok (o_mem_addr_ok),
    .o_mem_data_ok (o_mem_data_ok),
    .o_mem_rsp     (o_mem_rsp),
    .o_req_valid   (req_valid),
    .o_req         (req),
    .i_req_accept  (req_accept),
    .i_done        (done),
    .i_rsp         (rsp)
  );

  axi_master_bridge axi_master_bridge_i (
    .i_aclk       (i_aclk),
    .i_rst        (i_rst),
    .i_req_valid  (req_valid),
    .i_req        (req),
    .o_req_accept (req_accept),
    .o_done       (done),
    .o_rsp        (rsp),
    .o_aw         (aw),
    .o_awvalid    (awvalid),
    .i_awready    (awready),
    .o_w          (w),
    .o_wvalid     (wvalid),
    .i_wready     (wready),
    .i_bresp      (bresp),
    .i_bvalid     (bvalid),
    .o_bready     (bready),
    .o_ar         (ar),
    .o_arvalid    (arvalid),
    .i_arready    (arready),
    .i_r          (r),
    .i_rvalid     (rvalid),
    .o_rready     (rready)
  );

  axi_sram_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) axi_sram_slave_i (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_aw      (aw),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_w       (w),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_ar      (ar),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_r       (r),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

endmodule

/* dv/tb_clk_gen.sv */
// clock runs from time zero; reset is released 1 ns after its last rising edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 10
) (
  output logic o_aclk,
  output logic o_rst
);

  initial begin
    o_aclk = 1'b0;
    forever #(PERIOD_NS / 2) o_aclk = ~o_aclk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_aclk);
    #1 o_rst = 1'b0;  // same skew as the stimulus
  end

endmodule

/* dv/mem_subsys_tb.sv */
// MEM_WORDS is 256; checks sample on the falling edge, stimulus moves 1 ns after the rising edge
`timescale 1ns/1ps

module mem_subsys_tb;

  import axi_bus_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int CLK_NS      = 20;
  localparam int RST_CYCLES  = 10;
  localparam int RAND_OPS    = 200;  // write/read pairs on the data port
  localparam int MIX_OPS     = 60;   // per port while both compete
  localparam int ERR_ROUNDS  = 4;    // seven accesses each
  localparam int PLANNED_OPS = MEM_WORDS + 2 * RAND_OPS + 2 * MIX_OPS + 7 * ERR_ROUNDS;
  localparam int WATCHDOG_NS = (RST_CYCLES + 40 * PLANNED_OPS) * CLK_NS;

  logic    aclk;
  logic    rst;
  logic    if_req;
  addr_t   if_addr;
  logic    if_addr_ok;
  logic    if_data_ok;
  rw_rsp_t if_rsp;
  logic    mem_req;
  rw_req_t mem_cmd;
  logic    mem_addr_ok;
  logic    mem_data_ok;
  rw_rsp_t mem_rsp;

  // reference model and per-port bookkeeping, updated on the rising edge
  data_t   model [MEM_WORDS];
  logic    if_busy;
  logic    mem_busy;
  logic    mem_last;     // data port got the last grant
  int      if_age;
  int      mem_age;
  int      mem_lat;
  rw_rsp_t if_exp;
  rw_rsp_t mem_exp;
  int      n_accepted;
  int      n_answered;

  int data_errs   = 0;
  int order_errs  = 0;
  int timing_errs = 0;
  int end_errs    = 0;

  tb_clk_gen #(
    .PERIOD_NS  (CLK_NS),
    .RST_CYCLES (RST_CYCLES)
  ) tb_clk_gen_i (
    .o_aclk (aclk),
    .o_rst  (rst)
  );

  mem_subsys_top #(
    .MEM_WORDS (MEM_WORDS)
  ) mem_subsys_top_i (
    .i_aclk        (aclk),
    .i_rst         (rst),
    .i_if_req      (if_req),
    .i_if_addr     (if_addr),
    .o_if_addr_ok  (if_addr_ok),
    .o_if_data_ok  (if_data_ok),
    .o_if_rsp      (if_rsp),
    .i_mem_req     (mem_req),
    .i_mem_cmd     (mem_cmd),
    .o_mem_addr_ok (mem_addr_ok),
    .o_mem_data_ok (mem_data_ok),
    .o_mem_rsp     (mem_rsp)
  );

  // ----------------------------------------------------------------------
  // reference rules
  // ----------------------------------------------------------------------
  // past the last word, or not a multiple of the access size
  function automatic logic access_fails(input addr_t a, input size_t s);
    return (a >= addr_t'(MEM_WORDS * 8)) || ((a & addr_t'((1 << s) - 1)) != '0);
  endfunction

  function automatic rw_rsp_t read_expect(input addr_t a, input size_t s);
    rw_rsp_t r;
    r.err   = access_fails(a, s);
    r.rdata = r.err ? '0 : model[int'(a >> 3)];  // zero data on a fault
    return r;
  endfunction

  task automatic apply_write(input rw_req_t c);
    int idx;
    idx = int'(c.addr >> 3);
    if (!access_fails(c.addr, c.size)) begin
      for (int b = 0; b < 8; b++) begin
        if (c.strb[b]) model[idx][b*8 +: 8] = c.data[b*8 +: 8];
      end
    end
  endtask

  // model follows the order of acceptance, one transaction in flight
  always @(posedge aclk) begin
    if (rst) begin
      if_busy    <= 1'b0;
      mem_busy   <= 1'b0;
      mem_last   <= 1'b1;  // fetch wins the first tie
      n_accepted <= 0;
      n_answered <= 0;
    end else begin
      if (if_addr_ok) begin
        if_busy  <= 1'b1;
        if_age   <= 1;
        if_exp   <= read_expect(if_addr, 2'd3);  // fetch is always a full word
        mem_last <= 1'b0;
      end else if (if_busy) begin
        if_age <= if_age + 1;
      end
      if (mem_addr_ok) begin
        mem_busy <= 1'b1;
        mem_age  <= 1;
        mem_last <= 1'b1;
        mem_lat  <= mem_cmd.wr ? 4 : 3;
        if (mem_cmd.wr) begin
          apply_write(mem_cmd);
          mem_exp <= '{err: access_fails(mem_cmd.addr, mem_cmd.size), rdata: '0};
        end else begin
          mem_exp <= read_expect(mem_cmd.addr, mem_cmd.size);
        end
      end else if (mem_busy) begin
        mem_age <= mem_age + 1;
      end
      if (if_addr_ok || mem_addr_ok) n_accepted <= n_accepted + 1;
      if (if_data_ok) if_busy <= 1'b0;
      if (mem_data_ok) mem_busy <= 1'b0;
      if (if_data_ok || mem_data_ok) n_answered <= n_answered + 1;
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  a_reset_quiet: assert property (@(negedge aclk)
    rst |-> !(if_addr_ok || if_data_ok || mem_addr_ok || mem_data_ok))
    else begin
      order_errs++;
      $display("Error at %0t: handshake strobe high during reset", $time);
    end

  a_grant_needs_req: assert property (@(negedge aclk) disable iff (rst)
    (!if_addr_ok || if_req) && (!mem_addr_ok || mem_req) && !(if_addr_ok && mem_addr_ok))
    else begin
      order_errs++;
      $display("Error at %0t: addr_ok without a request or on both ports", $time);
    end

  a_round_robin: assert property (@(negedge aclk) disable iff (rst)
    (if_req && mem_req && (if_addr_ok || mem_addr_ok)) |-> (mem_addr_ok == !mem_last))
    else begin
      order_errs++;
      $display("Error at %0t: tie went to the port served last", $time);
    end

  a_rsp_owner: assert property (@(negedge aclk) disable iff (rst)
    (!if_data_ok || if_busy) && (!mem_data_ok || mem_busy))
    else begin
      order_errs++;
      $display("Error at %0t: data_ok on a port with nothing outstanding", $time);
    end

  a_if_data: assert property (@(negedge aclk) disable iff (rst)
    if_data_ok |-> (if_rsp == if_exp))
    else begin
      data_errs++;
      $display("Error at %0t: fetch rsp %h, expected %h", $time, if_rsp, if_exp);
    end

  a_mem_data: assert property (@(negedge aclk) disable iff (rst)
    mem_data_ok |-> (mem_rsp == mem_exp))
    else begin
      data_errs++;
      $display("Error at %0t: data rsp %h, expected %h", $time, mem_rsp, mem_exp);
    end

  a_if_latency: assert property (@(negedge aclk) disable iff (rst)
    if_data_ok |-> (if_age == 3))
    else begin
      timing_errs++;
      $display("Error at %0t: fetch data_ok after %0d cycles, expected 3", $time, if_age);
    end

  a_mem_latency: assert property (@(negedge aclk) disable iff (rst)
    mem_data_ok |-> (mem_age == mem_lat))
    else begin
      timing_errs++;
      $display("Error at %0t: data_ok after %0d cycles, expected %0d", $time, mem_age, mem_lat);
    end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  function automatic addr_t random_addr(input size_t size);
    int word;
    int off;
    word = int'($urandom % MEM_WORDS);
    off  = int'($urandom % 8) & ~((1 << size) - 1);  // aligned to the size
    return addr_t'(word * 8 + off);
  endfunction

  // holds the request until addr_ok, returns 1 ns after that edge
  task automatic mem_access(input logic wr, input size_t size, input addr_t addr,
                            input strb_t strb);
    mem_cmd = '{wr: wr, size: size, addr: addr, strb: strb, data: {$urandom, $urandom}};
    mem_req = 1'b1;
    @(posedge aclk);
    while (!mem_addr_ok) @(posedge aclk);
    #1;
  endtask

  task automatic fetch_access(input addr_t addr);
    if_addr = addr;
    if_req  = 1'b1;
    @(posedge aclk);
    while (!if_addr_ok) @(posedge aclk);
    #1;
  endtask

  task automatic wait_idle();
    mem_req = 1'b0;
    if_req  = 1'b0;
    @(posedge aclk);
    while (if_busy || mem_busy) @(posedge aclk);
    #1;
  endtask

  initial begin
    size_t sz;
    int    w;
    if_req  = 1'b0;
    if_addr = '0;
    mem_req = 1'b0;
    mem_cmd = '0;
    void'($urandom(32'h18a1_9f3a));
    @(negedge rst);
    @(posedge aclk);
    #1;

    // every word gets a full write before any read
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_access(1'b1, 2'd3, addr_t'(i * 8), 8'hff);
    end
    repeat (RAND_OPS) begin
      sz = size_t'($urandom % 4);
      mem_access(1'b1, sz, random_addr(sz), strb_t'($urandom));
      sz = size_t'($urandom % 4);
      mem_access(1'b0, sz, random_addr(sz), '0);
    end
    wait_idle();

    // both ports busy at once
    fork
      begin
        repeat (MIX_OPS) fetch_access(random_addr(2'd3));
        if_req = 1'b0;
      end
      begin
        repeat (MIX_OPS) begin
          sz = size_t'($urandom % 4);
          mem_access(($urandom % 4) != 0, sz, random_addr(sz), strb_t'($urandom));
        end
        mem_req = 1'b0;
      end
    join
    wait_idle();

    // faults, then a read of the same word
    repeat (ERR_ROUNDS) begin
      w = int'($urandom % MEM_WORDS);
      mem_access(1'b1, 2'd3, addr_t'((MEM_WORDS + w) * 8), 8'hff);
      mem_access(1'b0, 2'd3, addr_t'((MEM_WORDS + w) * 8), '0);
      mem_access(1'b1, 2'd2, addr_t'(w * 8 + 2), 8'hff);
      mem_access(1'b0, 2'd1, addr_t'(w * 8 + 1), '0);
      mem_access(1'b0, 2'd3, addr_t'(w * 8), '0);
      mem_req = 1'b0;
      fetch_access(addr_t'(w * 8 + 4));
      fetch_access(addr_t'((MEM_WORDS + w) * 8));
      if_req = 1'b0;
    end
    wait_idle();

    end_check: assert (n_accepted == n_answered) else begin
      end_errs++;
      $display("only %0d of %0d accepted requests were answered", n_answered, n_accepted);
    end

    $display("errors: data %0d, order %0d, timing %0d, end %0d",
             data_errs, order_errs, timing_errs, end_errs);
    if (data_errs + order_errs + timing_errs + end_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // ----------------------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------------------
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns, a handshake never came", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* project.f */
logic/axi_bus_pkg.sv
logic/rw_arbiter.sv
logic/axi_master_bridge.sv
logic/axi_sram_slave.sv
logic/mem_subsys_top.sv
dv/tb_clk_gen.sv
dv/mem_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module mem_subsys_tb \
  -f project.f -Mdir obj_dir -o mem_subsys_sim || exit 1

sim_out="$(./obj_dir/mem_subsys_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
